/* design/afe_bus_pkg.sv */
`default_nettype none

`include "afe_consts.svh"

package afe_bus_pkg;

  ////////////////////////////////////////////////////////////
  // AXI4-Lite response codes
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OKAY   = 2'b00,  // Normal access
    SLVERR = 2'b10   // Read-only or unmapped
  } axil_resp_e;

  ////////////////////////////////////////////////////////////
  // Master driven channel fields
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                      awvalid;
    logic [`AFE_ADDR_W-1:0]    awaddr;   // Byte address
    logic                      wvalid;
    logic [`AFE_DATA_W-1:0]    wdata;
    logic [`AFE_DATA_W/8-1:0]  wstrb;    // One bit per byte lane
    logic                      bready;
    logic                      arvalid;
    logic [`AFE_ADDR_W-1:0]    araddr;
    logic                      rready;
  } axil_req_t;

  // Slave driven channel fields
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    axil_resp_e                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [`AFE_DATA_W-1:0]    rdata;
    axil_resp_e                rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* design/afe_consts.svh */
`ifndef AFE_CONSTS_SVH
`define AFE_CONSTS_SVH

// Converter widths
`define AFE_ADC_W        16                // Raw ADC bus, two low bits reserved
`define AFE_SMP_W        14                // Signed sample width

// AXI4-Lite bus widths
`define AFE_ADDR_W       8
`define AFE_DATA_W       32

// Register word offsets
`define AFE_REG_CTRL     8'h00
`define AFE_REG_OFS_A    8'h04
`define AFE_REG_OFS_B    8'h08
`define AFE_REG_ADC_A    8'h0C
`define AFE_REG_ADC_B    8'h10
`define AFE_REG_ID       8'h14

// Read-only identification word, ASCII "AFE1"
`define AFE_ID           32'h4146_4531

// Fixed ADC strobe levels
`define AFE_ADC_CLK_OUT  2'b10             // Clock generation off
`define AFE_ADC_CDCS     1'b1              // Duty cycle stabilizer on

`endif

/* design/afe_dac_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afe_consts.svh"

module afe_dac_out
  import afe_signal_pkg::*;
(
  input  wire                   adc_clk,
  input  wire                   arst_n_i,
  input  wire sample_pair_t     dac_smp_i,    // Saturated samples
  output logic [`AFE_SMP_W-1:0] dac_dat_a_o,  // DAC code ch a
  output logic [`AFE_SMP_W-1:0] dac_dat_b_o   // DAC code ch b
);

  sample_t [1:0]              smp_vec;
  logic [1:0][`AFE_SMP_W-1:0] code_q;  // Output register

  assign smp_vec = dac_smp_i;

  ////////////////////////////////////////////////////////////
  // Two's complement to negative slope offset binary
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      // Code for a zero sample, mid scale
      for (int ch = 0; ch < 2; ch++)
        code_q[ch] <= {1'b0, {(`AFE_SMP_W-1){1'b1}}};
    end
    else
    begin
      for (int ch = 0; ch < 2; ch++)
        code_q[ch] <= {smp_vec[ch][`AFE_SMP_W-1], ~smp_vec[ch][`AFE_SMP_W-2:0]};
    end
  end

  assign dac_dat_a_o = code_q[0];
  assign dac_dat_b_o = code_q[1];

endmodule

`default_nettype wire

/* design/afe_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afe_consts.svh"

module afe_datapath
  import afe_signal_pkg::*;
(
  input  wire                  adc_clk,
  input  wire                  arst_n_i,
  input  wire [`AFE_ADC_W-1:0] adc_dat_a_i,  // Raw ADC ch a
  input  wire [`AFE_ADC_W-1:0] adc_dat_b_i,  // Raw ADC ch b
  input  wire afe_ctrl_t       ctrl_i,
  input  wire sample_pair_t    offset_i,
  output sample_pair_t         adc_smp_o,    // Converted or looped sample
  output sample_pair_t         dac_smp_o     // Saturated sum
);

  logic [1:0][`AFE_SMP_W-1:0] raw_q;    // Capture register
  sample_t [1:0]              adc_vec;
  sample_t [1:0]              ofs_vec;
  sample_t [1:0]              sum_d, sum_q;
  logic [1:0]                 feed;

  // Add in 15 bits, clamp on overflow of the top two bits
  function automatic sample_t sat_add(input sample_t x, input sample_t y);
    logic signed [`AFE_SMP_W:0] s;
    s = x + y;
    if (s[`AFE_SMP_W] != s[`AFE_SMP_W-1])
      return {s[`AFE_SMP_W], {(`AFE_SMP_W-1){~s[`AFE_SMP_W]}}};  // +8191 or -8192
    return s[`AFE_SMP_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // ADC capture
  ////////////////////////////////////////////////////////////

  // Low two bits are reserved on the 16-bit bus
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      raw_q <= '0;
    else
    begin
      raw_q[0] <= adc_dat_a_i[`AFE_ADC_W-1:`AFE_ADC_W-`AFE_SMP_W];
      raw_q[1] <= adc_dat_b_i[`AFE_ADC_W-1:`AFE_ADC_W-`AFE_SMP_W];
    end
  end

  ////////////////////////////////////////////////////////////
  // Conversion, loopback and summation
  ////////////////////////////////////////////////////////////

  assign ofs_vec = offset_i;                        // Struct to per-channel vector
  assign feed    = {ctrl_i.feed_b, ctrl_i.feed_a};

  always_comb
  begin
    for (int ch = 0; ch < 2; ch++)
    begin
      // Negative slope code, keep sign and flip the rest
      adc_vec[ch] = ctrl_i.digital_loop ? sum_q[ch]
                                        : {raw_q[ch][`AFE_SMP_W-1], ~raw_q[ch][`AFE_SMP_W-2:0]};
      sum_d[ch]   = sat_add(ofs_vec[ch], feed[ch] ? adc_vec[ch] : '0);  // Offset plus gated sample
    end
  end

  // Sum register, one new sample per cycle
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      sum_q <= '0;
    else
      sum_q <= sum_d;
  end

  assign adc_smp_o = adc_vec;
  assign dac_smp_o = sum_q;

endmodule

`default_nettype wire

/* design/afe_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afe_consts.svh"

module afe_regs
  import afe_bus_pkg::*, afe_signal_pkg::*;
(
  input  wire          adc_clk,     // ADC clock
  input  wire          arst_n_i,    // Async reset, active low
  input  wire axil_req_t    axil_req_i,
  output axil_rsp_t    axil_rsp_o,
  input  wire sample_pair_t adc_smp_i,  // Live samples for readback
  output afe_ctrl_t    ctrl_o,
  output sample_pair_t offset_o,
  output logic [7:0]   led_o
);

  typedef enum logic [1:0] {IDLE, WRESP, RRESP} state_e;

  state_e                  state_q, state_d;
  afe_ctrl_t               ctrl_q;
  sample_pair_t            ofs_q;
  reg_addr_e               wr_addr, rd_addr;
  logic                    wr_req, wr_fire, rd_fire;
  logic                    wr_err, rd_err;
  logic [`AFE_DATA_W-1:0]  rd_data, rdata_q;
  axil_resp_e              bresp_q, rresp_q;

  // Byte lane merge into a 14-bit offset
  function automatic sample_t ofs_merge(input sample_t cur,
                                        input logic [`AFE_DATA_W-1:0] data,
                                        input logic [`AFE_DATA_W/8-1:0] strb);
    sample_t nxt;
    nxt = cur;
    if (strb[0]) nxt[7:0] = data[7:0];
    if (strb[1]) nxt[`AFE_SMP_W-1:8] = data[`AFE_SMP_W-1:8];  // Upper bits beyond 13 dropped
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign wr_req  = axil_req_i.awvalid && axil_req_i.wvalid;
  assign wr_fire = (state_q == IDLE) && wr_req;                           // AW and W together
  assign rd_fire = (state_q == IDLE) && !wr_req && axil_req_i.arvalid;  // Write wins

  assign wr_addr = reg_addr_e'(axil_req_i.awaddr);
  assign rd_addr = reg_addr_e'(axil_req_i.araddr);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (wr_fire) state_d = WRESP;
               else if (rd_fire) state_d = RRESP;
      WRESP:   if (axil_req_i.bready) state_d = IDLE;
      RRESP:   if (axil_req_i.rready) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  // Only writable offsets answer OKAY
  assign wr_err = !(wr_addr inside {REG_CTRL, REG_OFS_A, REG_OFS_B});

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ctrl_q <= '0;
      ofs_q  <= '0;
    end
    else if (wr_fire)
    begin
      case (wr_addr)
        REG_CTRL:
        begin
          if (axil_req_i.wstrb[0])
          begin
            ctrl_q.digital_loop <= axil_req_i.wdata[0];
            ctrl_q.feed_a       <= axil_req_i.wdata[1];
            ctrl_q.feed_b       <= axil_req_i.wdata[2];
          end
          if (axil_req_i.wstrb[1]) ctrl_q.led      <= axil_req_i.wdata[15:8];
          if (axil_req_i.wstrb[2]) ctrl_q.reserved <= axil_req_i.wdata[23:16];
        end
        REG_OFS_A: ofs_q.a <= ofs_merge(ofs_q.a, axil_req_i.wdata, axil_req_i.wstrb);
        REG_OFS_B: ofs_q.b <= ofs_merge(ofs_q.b, axil_req_i.wdata, axil_req_i.wstrb);
        default: ;  // Read-only or unmapped, nothing changes
      endcase
    end
  end

  // Read mux, samples sign extended
  always_comb
  begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (rd_addr)
      REG_CTRL:  rd_data = {8'h00, ctrl_q.reserved, ctrl_q.led, 5'h00,
                            ctrl_q.feed_b, ctrl_q.feed_a, ctrl_q.digital_loop};
      REG_OFS_A: rd_data = `AFE_DATA_W'(ofs_q.a);
      REG_OFS_B: rd_data = `AFE_DATA_W'(ofs_q.b);
      REG_ADC_A: rd_data = `AFE_DATA_W'(adc_smp_i.a);
      REG_ADC_B: rd_data = `AFE_DATA_W'(adc_smp_i.b);
      REG_ID:    rd_data = `AFE_ID;
      default:   rd_err  = 1'b1;  // Unmapped reads back zero
    endcase
  end

  // Response payload, held while valid is up
  always_ff @(posedge adc_clk)
  begin
    if (wr_fire) bresp_q <= wr_err ? SLVERR : OKAY;
    if (rd_fire)
    begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? SLVERR : OKAY;
    end
  end

  always_comb
  begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = wr_fire;
    axil_rsp_o.wready  = wr_fire;
    axil_rsp_o.bvalid  = (state_q == WRESP);
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = (state_q == IDLE) && !wr_req;
    axil_rsp_o.rvalid  = (state_q == RRESP);
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  assign ctrl_o   = ctrl_q;
  assign offset_o = ofs_q;
  assign led_o    = ctrl_q.led;  // Housekeeping LED byte

endmodule

`default_nettype wire

/* design/afe_signal_pkg.sv */
`default_nettype none

`include "afe_consts.svh"

package afe_signal_pkg;

  ////////////////////////////////////////////////////////////
  // Sample types
  ////////////////////////////////////////////////////////////

  // Two's complement sample, full scale -8192..+8191
  typedef logic signed [`AFE_SMP_W-1:0] sample_t;

  // Channel a sits in the low half so the pair maps onto sample_t [1:0]
  typedef struct packed {
    sample_t b;  // Channel 2
    sample_t a;  // Channel 1
  } sample_pair_t;

  ////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////

  typedef enum logic [`AFE_ADDR_W-1:0] {
    REG_CTRL  = `AFE_REG_CTRL,   // Loop, feed enables, LED
    REG_OFS_A = `AFE_REG_OFS_A,  // Offset level ch a
    REG_OFS_B = `AFE_REG_OFS_B,  // Offset level ch b
    REG_ADC_A = `AFE_REG_ADC_A,  // Live sample ch a, read only
    REG_ADC_B = `AFE_REG_ADC_B,  // Live sample ch b, read only
    REG_ID    = `AFE_REG_ID      // Identification, read only
  } reg_addr_e;

  // CTRL contents, bits 23:16 of the word hold the spare byte
  typedef struct packed {
    logic [7:0] reserved;      // Spare, stored and read back
    logic [7:0] led;           // Word bits 15:8
    logic       feed_b;        // Word bit 2
    logic       feed_a;        // Word bit 1
    logic       digital_loop;  // Word bit 0
  } afe_ctrl_t;

endpackage

`default_nettype wire

/* design/afe_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afe_consts.svh"

module afe_top
  import afe_bus_pkg::*, afe_signal_pkg::*;
(
  input  wire                   adc_clk,      // Single system clock
  input  wire                   arst_n_i,
  // Configuration bus
  input  wire axil_req_t        axil_req_i,
  output axil_rsp_t             axil_rsp_o,
  // ADC
  input  wire [`AFE_ADC_W-1:0]  adc_dat_a_i,
  input  wire [`AFE_ADC_W-1:0]  adc_dat_b_i,
  output logic [1:0]            adc_clk_o,    // Optional ADC clock source
  output logic                  adc_cdcs_o,   // Duty cycle stabilizer
  // DAC
  output logic [`AFE_SMP_W-1:0] dac_dat_a_o,
  output logic [`AFE_SMP_W-1:0] dac_dat_b_o,
  // LED
  output logic [7:0]            led_o
);

  afe_ctrl_t    ctrl;
  sample_pair_t offset;
  sample_pair_t adc_smp;   // Back to registers for readback
  sample_pair_t dac_smp;

  ////////////////////////////////////////////////////////////
  // Fixed ADC pins
  ////////////////////////////////////////////////////////////

  assign adc_clk_o  = `AFE_ADC_CLK_OUT;
  assign adc_cdcs_o = `AFE_ADC_CDCS;

  // Decode stage
  afe_regs u_regs (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .adc_smp_i  (adc_smp),
    .ctrl_o     (ctrl),
    .offset_o   (offset),
    .led_o      (led_o)
  );

  // Execute stage, capture and sum registers
  afe_datapath u_datapath (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .ctrl_i      (ctrl),
    .offset_i    (offset),
    .adc_smp_o   (adc_smp),
    .dac_smp_o   (dac_smp)
  );

  // Result stage, output register
  afe_dac_out u_dac_out (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .dac_smp_i   (dac_smp),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/afe_bus_pkg.sv
design/afe_signal_pkg.sv
design/afe_regs.sv
design/afe_datapath.sv
design/afe_dac_out.sv
design/afe_top.sv
tests/afe_checker.sv
tests/afe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module afe_tb \
    -Mdir obj_dir -o afe_sim \
  && ./obj_dir/afe_sim 2>&1 | tee "$LOG" \
  || { echo "build or run failed"; exit 1; }

grep -q "^Simulation PASSED$" "$LOG" && exit 0 || exit 1

/* tests/afe_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module afe_checker
  import afe_bus_pkg::*;
(
  input wire            adc_clk,
  input wire            arst_n_i,
  input wire axil_req_t axil_req_i,
  input wire axil_rsp_t axil_rsp_i   // Slave outputs, observed only
);

  ////////////////////////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////////////////////////

  a_bvalid_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else $error("bvalid dropped before bready");

  // Read data frozen while the master stalls
  a_rvalid_hold: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
    else $error("rvalid or rdata changed before rready");

  a_no_accept_busy: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (axil_rsp_i.bvalid || axil_rsp_i.rvalid) |-> !(axil_rsp_i.awready || axil_rsp_i.wready))
    else $error("write accepted with a response pending");

  // No response out of reset
  a_reset_idle: assert property (@(posedge adc_clk)
    !arst_n_i |-> !axil_rsp_i.bvalid && !axil_rsp_i.rvalid)
    else $error("response valid during reset");

endmodule

bind afe_regs afe_checker u_checker (
  .adc_clk    (adc_clk),
  .arst_n_i   (arst_n_i),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o)
);

`default_nettype wire

/* tests/afe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "afe_consts.svh"

module afe_tb
  import afe_bus_pkg::*, afe_signal_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 16;
  localparam int N_ITER     = 8;                           // Random passes per test
  localparam int SETTLE     = 3;                           // Capture, sum, output
  localparam int BUS_LIMIT  = 20;                          // Cycles before a handshake is lost
  localparam int TX_CYCLES  = 10;                          // One bus transfer, worst case
  localparam int SMP_MAX    = (1 << (`AFE_SMP_W - 1)) - 1;
  localparam int SMP_MIN    = -(1 << (`AFE_SMP_W - 1));
  localparam logic [31:0] CTRL_MASK = 32'h00FF_FF07;       // Loop, feeds, LED, spare byte

  // Test lengths in cycles
  localparam int T_RESET = 6 * TX_CYCLES;
  localparam int T_REGS  = (6 * N_ITER + 10) * TX_CYCLES;
  localparam int T_FEED  = 3 * TX_CYCLES + N_ITER * (SETTLE + 1 + 4 * TX_CYCLES);
  localparam int T_SAT   = (2 * N_ITER + 4) * (2 * TX_CYCLES + SETTLE + 1) + 2 * TX_CYCLES;
  localparam int T_LOOP  = 6 * TX_CYCLES + 3 * (SETTLE + 1 + 2 * TX_CYCLES);
  localparam int RUN_CYCLES = RST_CYCLES + T_RESET + T_REGS + T_FEED + T_SAT + T_LOOP;

  logic                  adc_clk;
  logic                  arst_n_i;
  axil_req_t             req;
  axil_rsp_t             rsp;
  logic [`AFE_ADC_W-1:0] adc_a, adc_b;
  logic [1:0]            adc_clk_o;
  logic                  adc_cdcs_o;
  logic [`AFE_SMP_W-1:0] dac_a, dac_b;
  logic [7:0]            led;
  logic [31:0]           lfsr_q;
  int                    errors, checks, tests, test_err0;
  string                 cur_test;

  afe_top uut (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .axil_req_i  (req),
    .axil_rsp_o  (rsp),
    .adc_dat_a_i (adc_a),
    .adc_dat_b_i (adc_b),
    .adc_clk_o   (adc_clk_o),
    .adc_cdcs_o  (adc_cdcs_o),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .led_o       (led)
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  // Watchdog at twice the summed test lengths
  initial
  begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("error: watchdog expired after %0d cycles, a test is stuck", 2 * RUN_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};      // Taps 32, 22, 2, 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);                       // One step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Negative slope ADC code from full scale down to zero
  function automatic sample_t conv_adc(input logic [`AFE_ADC_W-1:0] raw);
    return sample_t'(SMP_MAX - int'(raw[`AFE_ADC_W-1:2]));
  endfunction

  // Raw ADC word that converts to c with random reserved bits
  function automatic logic [`AFE_ADC_W-1:0] raw_of(input sample_t c);
    return {`AFE_SMP_W'(SMP_MAX - int'(c)), 2'(rand_bits(2))};
  endfunction

  function automatic logic [`AFE_SMP_W-1:0] code_of(input sample_t s);
    return `AFE_SMP_W'(SMP_MAX - int'(s));              // Mid scale for zero
  endfunction

  function automatic sample_t sat_sum(input sample_t x, input sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > SMP_MAX)
      s = SMP_MAX;
    else if (s < SMP_MIN)
      s = SMP_MIN;
    return sample_t'(s);
  endfunction

  function automatic logic [31:0] word_of(input sample_t s);
    return {{(32 - `AFE_SMP_W){s[`AFE_SMP_W-1]}}, s};   // Sign extended readback
  endfunction

  // Byte lane merge as the bus writes it
  function automatic logic [31:0] merge_lanes(input logic [31:0] cur, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] nxt;
    nxt = cur;
    for (int i = 0; i < 4; i++)
      if (strb[i])
        nxt[8*i +: 8] = data[8*i +: 8];
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks and test bookkeeping
  ////////////////////////////////////////////////////////////

  task automatic check_sample(input string what, input sample_t exp, input sample_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s %s: expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_code(input string what, input logic [`AFE_SMP_W-1:0] exp,
                            input logic [`AFE_SMP_W-1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input axil_resp_e exp, input axil_resp_e act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s %s: expected %s actual %s", cur_test, what, exp.name(), act.name());
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_err0)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d errors", cur_test, errors - test_err0);
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axil_resp_e resp);
    int n;
    int hold;
    n    = 0;
    hold = int'(rand_bits(2));                          // bready held off 0 to 3 cycles
    @(negedge adc_clk);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = strb;
    #1;                                                 // Ready is combinational
    while (!(rsp.awready && rsp.wready) && n < BUS_LIMIT)
    begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    @(negedge adc_clk);                                 // Taken on the edge between
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    #1;
    while (!rsp.bvalid && n < BUS_LIMIT)
    begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    repeat (hold) @(negedge adc_clk);                   // bvalid held by the slave
    req.bready = 1'b1;
    resp = rsp.bresp;
    @(negedge adc_clk);
    req.bready = 1'b0;
    if (n >= BUS_LIMIT)
    begin
      errors++;
      $display("error in %s: write to %h got no handshake", cur_test, addr);
    end
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output axil_resp_e resp);
    int n;
    int hold;
    n    = 0;
    hold = int'(rand_bits(2));                          // Back-pressure of 0 to 3 cycles
    @(negedge adc_clk);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    #1;
    while (!rsp.arready && n < BUS_LIMIT)
    begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    @(negedge adc_clk);
    req.arvalid = 1'b0;
    #1;
    while (!rsp.rvalid && n < BUS_LIMIT)
    begin
      @(negedge adc_clk);
      #1;
      n++;
    end
    req.awvalid = (hold != 0);                          // Competing write waits for rready
    req.wvalid  = (hold != 0);
    repeat (hold) @(negedge adc_clk);                   // rvalid held by the slave
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.rready  = 1'b1;
    data = rsp.rdata;
    resp = rsp.rresp;
    @(negedge adc_clk);
    req.rready = 1'b0;
    if (n >= BUS_LIMIT)
    begin
      errors++;
      $display("error in %s: read of %h got no handshake", cur_test, addr);
    end
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    axil_resp_e resp;
    axil_write(addr, data, 4'hF, resp);
    check_resp("write resp", OKAY, resp);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                            input axil_resp_e exp_resp, input string what);
    logic [31:0] data;
    axil_resp_e  resp;
    axil_read(addr, data, resp);
    check_resp({what, " resp"}, exp_resp, resp);
    check_word(what, exp, data);
  endtask

  task automatic read_sample(input logic [7:0] addr, input sample_t exp, input string what);
    logic [31:0] data;
    axil_resp_e  resp;
    axil_read(addr, data, resp);
    check_resp({what, " resp"}, OKAY, resp);
    check_sample(what, exp, sample_t'(data[`AFE_SMP_W-1:0]));
    check_word({what, " ext"}, word_of(exp), data);
  endtask

  // Offsets, ADC inputs and the expected DAC codes
  task automatic sum_case(input logic feed, input sample_t ofs_a, input sample_t ofs_b,
                          input logic [`AFE_ADC_W-1:0] raw_a, input logic [`AFE_ADC_W-1:0] raw_b);
    sample_t exp_a, exp_b;
    write_ok(REG_OFS_A, word_of(ofs_a));
    write_ok(REG_OFS_B, word_of(ofs_b));
    @(negedge adc_clk);
    adc_a = raw_a;
    adc_b = raw_b;
    exp_a = sat_sum(ofs_a, feed ? conv_adc(raw_a) : sample_t'(0));
    exp_b = sat_sum(ofs_b, feed ? conv_adc(raw_b) : sample_t'(0));
    repeat (SETTLE) @(negedge adc_clk);
    check_code("dac_a", code_of(exp_a), dac_a);
    check_code("dac_b", code_of(exp_b), dac_b);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    begin_test("reset");
    check_code("dac_a", code_of(sample_t'(0)), dac_a);
    check_code("dac_b", code_of(sample_t'(0)), dac_b);
    check_word("led", 32'h0, {24'h0, led});
    check_word("adc_clk_o", {30'h0, `AFE_ADC_CLK_OUT}, {30'h0, adc_clk_o});
    check_word("adc_cdcs_o", {31'h0, `AFE_ADC_CDCS}, {31'h0, adc_cdcs_o});
    read_check(REG_CTRL, 32'h0, OKAY, "ctrl");
    read_check(REG_OFS_A, 32'h0, OKAY, "ofs_a");
    read_check(REG_OFS_B, 32'h0, OKAY, "ofs_b");
    read_check(REG_ID, `AFE_ID, OKAY, "id");
    end_test();
  endtask

  task automatic test_regs();
    logic [31:0] ctrl_m, ofs_a_m, ofs_b_m, data;
    logic [3:0]  strb;
    axil_resp_e  resp;
    begin_test("regs");
    ctrl_m  = '0;                                       // Reset values
    ofs_a_m = '0;
    ofs_b_m = '0;
    for (int i = 0; i < N_ITER; i++)
    begin
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      axil_write(REG_CTRL, data, strb, resp);
      check_resp("ctrl write", OKAY, resp);
      ctrl_m = merge_lanes(ctrl_m, data, strb) & CTRL_MASK;
      read_check(REG_CTRL, ctrl_m, OKAY, "ctrl");
      check_word("led", {24'h0, ctrl_m[15:8]}, {24'h0, led});
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      axil_write(REG_OFS_A, data, strb, resp);
      check_resp("ofs_a write", OKAY, resp);
      ofs_a_m = merge_lanes(ofs_a_m, data, strb);
      read_sample(REG_OFS_A, sample_t'(ofs_a_m[`AFE_SMP_W-1:0]), "ofs_a");
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      axil_write(REG_OFS_B, data, strb, resp);
      check_resp("ofs_b write", OKAY, resp);
      ofs_b_m = merge_lanes(ofs_b_m, data, strb);
      read_sample(REG_OFS_B, sample_t'(ofs_b_m[`AFE_SMP_W-1:0]), "ofs_b");
    end
    // Read-only and unmapped targets
    data = rand_bits(32);
    axil_write(REG_ID, data, 4'hF, resp);
    check_resp("id write", SLVERR, resp);
    axil_write(8'h20, data, 4'hF, resp);
    check_resp("unmapped write", SLVERR, resp);
    axil_write(REG_ADC_A, data, 4'hF, resp);
    check_resp("adc_a write", SLVERR, resp);
    read_check(REG_CTRL, ctrl_m, OKAY, "ctrl kept");
    read_sample(REG_OFS_A, sample_t'(ofs_a_m[`AFE_SMP_W-1:0]), "ofs_a kept");
    read_sample(REG_OFS_B, sample_t'(ofs_b_m[`AFE_SMP_W-1:0]), "ofs_b kept");
    read_check(REG_ID, `AFE_ID, OKAY, "id kept");
    read_check(8'h20, 32'h0, SLVERR, "unmapped read");
    end_test();
  endtask

  task automatic test_feed();
    begin_test("feed");
    write_ok(REG_CTRL, 32'h6);                          // Both feeds without loop
    write_ok(REG_OFS_A, 32'h0);
    write_ok(REG_OFS_B, 32'h0);
    for (int i = 0; i < N_ITER; i++)
    begin
      @(negedge adc_clk);
      adc_a = `AFE_ADC_W'(rand_bits(`AFE_ADC_W));
      adc_b = `AFE_ADC_W'(rand_bits(`AFE_ADC_W));
      repeat (SETTLE) @(negedge adc_clk);               // Exactly the pipeline depth
      check_code("dac_a", adc_a[`AFE_ADC_W-1:2], dac_a);
      check_code("dac_b", adc_b[`AFE_ADC_W-1:2], dac_b);
      read_sample(REG_ADC_A, conv_adc(adc_a), "adc_a");
      read_sample(REG_ADC_B, conv_adc(adc_b), "adc_b");
    end
    end_test();
  endtask

  task automatic test_offset_sat();
    begin_test("offset_sat");
    write_ok(REG_CTRL, 32'h0);                          // Offset alone
    for (int i = 0; i < N_ITER; i++)
      sum_case(1'b0, sample_t'(rand_bits(`AFE_SMP_W)), sample_t'(rand_bits(`AFE_SMP_W)),
               `AFE_ADC_W'(rand_bits(`AFE_ADC_W)), `AFE_ADC_W'(rand_bits(`AFE_ADC_W)));
    write_ok(REG_CTRL, 32'h6);
    for (int i = 0; i < N_ITER; i++)
      sum_case(1'b1, sample_t'(rand_bits(`AFE_SMP_W)), sample_t'(rand_bits(`AFE_SMP_W)),
               `AFE_ADC_W'(rand_bits(`AFE_ADC_W)), `AFE_ADC_W'(rand_bits(`AFE_ADC_W)));
    // Near full scale with positive a and negative b
    sum_case(1'b1, sample_t'(SMP_MAX), sample_t'(SMP_MIN),
             raw_of(sample_t'(SMP_MAX)), raw_of(sample_t'(SMP_MIN)));
    sum_case(1'b1, sample_t'(8000), sample_t'(-8000), raw_of(sample_t'(500)),
             raw_of(sample_t'(-500)));
    sum_case(1'b1, sample_t'(SMP_MAX), sample_t'(SMP_MIN), raw_of(sample_t'(1)),
             raw_of(sample_t'(-1)));
    sum_case(1'b1, sample_t'(SMP_MIN), sample_t'(SMP_MAX), raw_of(sample_t'(-1)),
             raw_of(sample_t'(1)));
    end_test();
  endtask

  task automatic test_loopback();
    sample_t x, y;
    begin_test("loopback");
    x = sample_t'(rand_bits(`AFE_SMP_W));
    y = sample_t'(rand_bits(`AFE_SMP_W));
    write_ok(REG_OFS_A, word_of(x));
    write_ok(REG_OFS_B, word_of(y));
    write_ok(REG_CTRL, 32'h1);                          // Loop on and feeds off
    for (int i = 0; i < 2; i++)
    begin
      @(negedge adc_clk);
      adc_a = `AFE_ADC_W'(rand_bits(`AFE_ADC_W));
      adc_b = `AFE_ADC_W'(rand_bits(`AFE_ADC_W));
      repeat (SETTLE) @(negedge adc_clk);
      read_sample(REG_ADC_A, x, "loop adc_a");        // Input ignored
      read_sample(REG_ADC_B, y, "loop adc_b");
      check_code("dac_a", code_of(x), dac_a);
    end
    write_ok(REG_CTRL, 32'h0);
    repeat (SETTLE) @(negedge adc_clk);
    read_sample(REG_ADC_A, conv_adc(adc_a), "adc_a");
    read_sample(REG_ADC_B, conv_adc(adc_b), "adc_b");
    end_test();
  endtask

  initial
  begin
    adc_clk  = 1'b0;
    arst_n_i = 1'b0;
    req      = '0;
    adc_a    = '0;
    adc_b    = '0;
    lfsr_q   = 32'hbc5d;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    repeat (RST_CYCLES) @(negedge adc_clk);
    arst_n_i = 1'b1;
    repeat (2) @(negedge adc_clk);
    test_reset();
    test_regs();
    test_feed();
    test_offset_sat();
    test_loopback();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
